// ==== source/fetch_pkg.sv ====
package fetch_pkg;

  ////////////////////
  // Basic types
  ////////////////////

  typedef logic [31:0] addr_t;    // Byte address.
  typedef logic [31:0] inst_t;    // Instruction word, also one AXI read data word.
  typedef logic [6:0]  opcode_t;  // Low seven bits of an instruction.

  ////////////////////
  // RV32 opcodes
  ////////////////////

  // These opcodes end the straight-line run. Fetch waits for execute to supply the next PC.
  localparam opcode_t OP_JAL    = 7'b110_1111;
  localparam opcode_t OP_JALR   = 7'b110_0111;
  localparam opcode_t OP_B_TYPE = 7'b110_0011;
  localparam opcode_t OP_SYSTEM = 7'b111_0011;

  // fence.i with all operand fields zero.
  localparam inst_t INST_FENCE_I = 32'h0000_100f;

  ////////////////////
  // Cache line geometry
  ////////////////////

  localparam int LINE_WORDS = 2;  // Words per cache line.
  localparam int OFFSET_W   = 1;  // Word offset bits within a line.

  // First fetch address unless the top level overrides it.
  localparam addr_t DEFAULT_RESET_PC = 32'h8000_0000;

endpackage

// ==== source/axil_read_master.sv ====
`timescale 1ns/100ps

module axil_read_master (
  input  logic                clk,
  input  logic                rst,
  // Single-word request from the cache.
  input  logic                rd_req_valid_i,
  input  fetch_pkg::addr_t    rd_req_addr_i,
  output logic                rd_req_ready_o,
  output logic                rd_rsp_valid_o,
  output fetch_pkg::inst_t    rd_rsp_data_o,
  // AXI4-Lite read address channel.
  output fetch_pkg::addr_t    araddr_o,
  output logic [2:0]          arprot_o,
  output logic                arvalid_o,
  input  logic                arready_i,
  // AXI4-Lite read data channel.
  input  fetch_pkg::inst_t    rdata_i,
  input  logic [1:0]          rresp_i,
  input  logic                rvalid_i,
  output logic                rready_o
);
  import fetch_pkg::*;

  // Unprivileged, secure, instruction access.
  localparam logic [2:0] ARPROT_INST = 3'b100;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_t;

  state_t state_q;
  addr_t  addr_q;
  logic   rsp_valid_q;
  inst_t  rsp_data_q;

  assign rd_req_ready_o = (state_q == ST_IDLE);
  assign arvalid_o      = (state_q == ST_ADDR);
  assign araddr_o       = addr_q;
  assign arprot_o       = ARPROT_INST;
  assign rready_o       = (state_q == ST_DATA);  // Only while a read is outstanding.

  // The response is registered, so the cache sees a clean one-cycle pulse.
  assign rd_rsp_valid_o = rsp_valid_q;
  assign rd_rsp_data_o  = rsp_data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ST_IDLE;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (rd_req_valid_i) begin
            state_q <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (arready_i) begin
            state_q <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (rvalid_i) begin
            state_q     <= ST_IDLE;
            rsp_valid_q <= 1'b1;  // rresp_i is not checked, there is no error path.
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Address and read data payload.
  always_ff @(posedge clk) begin
    if (rd_req_ready_o && rd_req_valid_i) begin
      addr_q <= rd_req_addr_i;  // Held stable through the AR handshake.
    end
    if (rready_o && rvalid_i) begin
      rsp_data_q <= rdata_i;
    end
  end

endmodule

// ==== source/l1i_cache.sv ====
`timescale 1ns/100ps

module l1i_cache #(
  parameter int L1I_INDEX_W = 2
) (
  input  logic             clk,
  input  logic             rst,
  // Lookup from the fetch unit.
  input  fetch_pkg::addr_t lookup_pc_i,
  output logic             hit_o,
  output fetch_pkg::inst_t hit_inst_o,
  input  logic             invalidate_i,
  // Refill requests towards the AXI read master.
  output logic             rd_req_valid_o,
  output fetch_pkg::addr_t rd_req_addr_o,
  input  logic             rd_req_ready_i,
  input  logic             rd_rsp_valid_i,
  input  fetch_pkg::inst_t rd_rsp_data_i
);
  import fetch_pkg::*;

  localparam int SETS  = 1 << L1I_INDEX_W;
  localparam int TAG_W = 32 - L1I_INDEX_W - OFFSET_W - 2;

  typedef logic [TAG_W-1:0]       tag_t;
  typedef logic [L1I_INDEX_W-1:0] index_t;
  typedef logic [OFFSET_W-1:0]    offset_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REQ0,
    ST_WAIT0,
    ST_REQ1,
    ST_WAIT1
  } state_t;

  ////////////////////
  // Storage
  ////////////////////

  logic [SETS-1:0] valid_q;
  tag_t            tag_mem  [SETS];
  inst_t           data_mem [SETS][LINE_WORDS];

  state_t state_q;
  tag_t   refill_tag_q;
  index_t refill_idx_q;

  ////////////////////
  // Lookup
  ////////////////////

  tag_t    lookup_tag;
  index_t  lookup_idx;
  offset_t lookup_off;
  logic    line_match;
  offset_t req_word;

  assign lookup_tag = lookup_pc_i[31 -: TAG_W];
  assign lookup_idx = lookup_pc_i[OFFSET_W + 2 +: L1I_INDEX_W];
  assign lookup_off = lookup_pc_i[2 +: OFFSET_W];

  assign line_match = valid_q[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);

  // A line is never reported while the arrays are being rewritten.
  assign hit_o      = (state_q == ST_IDLE) && line_match;
  assign hit_inst_o = data_mem[lookup_idx][lookup_off];

  ////////////////////
  // Refill
  ////////////////////

  assign req_word       = (state_q == ST_REQ1) ? offset_t'(1) : offset_t'(0);
  assign rd_req_valid_o = (state_q == ST_REQ0) || (state_q == ST_REQ1);
  assign rd_req_addr_o  = {refill_tag_q, refill_idx_q, req_word, 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      valid_q <= '0;
    end else begin
      if (invalidate_i) begin
        valid_q <= '0;
      end
      case (state_q)
        ST_IDLE: begin
          if (!line_match) begin
            state_q <= ST_REQ0;
          end
        end
        ST_REQ0: begin
          if (rd_req_ready_i) begin
            state_q <= ST_WAIT0;
          end
        end
        ST_WAIT0: begin
          if (rd_rsp_valid_i) begin
            state_q <= ST_REQ1;
          end
        end
        ST_REQ1: begin
          if (rd_req_ready_i) begin
            state_q <= ST_WAIT1;
          end
        end
        ST_WAIT1: begin
          if (rd_rsp_valid_i) begin
            state_q <= ST_IDLE;
            // Set after the clear above. The new line follows the fence in program order.
            valid_q[refill_idx_q] <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Line address of the refill and the array writes.
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && !line_match) begin
      refill_tag_q <= lookup_tag;
      refill_idx_q <= lookup_idx;
    end
    if (state_q == ST_WAIT0 && rd_rsp_valid_i) begin
      data_mem[refill_idx_q][0] <= rd_rsp_data_i;
    end
    if (state_q == ST_WAIT1 && rd_rsp_valid_i) begin
      data_mem[refill_idx_q][1] <= rd_rsp_data_i;
      tag_mem[refill_idx_q]     <= refill_tag_q;
    end
  end

endmodule

// ==== source/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit #(
  parameter fetch_pkg::addr_t RESET_PC = fetch_pkg::DEFAULT_RESET_PC
) (
  input  logic             clk,
  input  logic             rst,
  // Decode handshake.
  output logic             inst_valid_o,
  input  logic             inst_ready_i,
  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::addr_t pc_o,
  // Next PC from execute after a branch.
  input  logic             redirect_valid_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  // Cache lookup.
  output fetch_pkg::addr_t lookup_pc_o,
  input  logic             hit_i,
  input  fetch_pkg::inst_t hit_inst_i,
  output logic             invalidate_o
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    ST_RUN,
    ST_STALL,
    ST_REDIRECT
  } state_t;

  state_t  state_q;
  state_t  state_d;
  addr_t   pc_q;
  addr_t   pc_d;
  opcode_t opcode;
  logic    offer;
  logic    xfer;
  logic    is_branch;
  logic    is_fence_i;

  ////////////////////
  // Decode side
  ////////////////////

  // PC only moves on a transfer or a redirect, so the offer holds under back-pressure.
  assign offer = hit_i && (state_q != ST_STALL);
  assign xfer  = offer && inst_ready_i;

  assign inst_valid_o = offer;
  assign inst_o       = hit_inst_i;
  assign pc_o         = pc_q;
  assign lookup_pc_o  = pc_q;

  assign opcode = hit_inst_i[6:0];

  always_comb begin
    is_branch = 1'b0;
    case (opcode)
      OP_JAL, OP_JALR, OP_B_TYPE, OP_SYSTEM: is_branch = 1'b1;
      default:                               is_branch = 1'b0;
    endcase
  end

  assign is_fence_i   = (hit_inst_i == INST_FENCE_I);
  assign invalidate_o = xfer && is_fence_i;  // One cycle, on the transfer itself.

  ////////////////////
  // PC and stall
  ////////////////////

  always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    case (state_q)
      ST_RUN, ST_REDIRECT: begin
        // The first instruction at a redirect target is handled like any other.
        if (xfer) begin
          if (is_branch) begin
            state_d = ST_STALL;  // PC stays on the branch until execute answers.
          end else begin
            pc_d    = pc_q + 32'd4;
            state_d = ST_RUN;
          end
        end else if (state_q == ST_REDIRECT) begin
          state_d = ST_RUN;
        end
      end
      ST_STALL: begin
        if (redirect_valid_i) begin
          pc_d    = redirect_pc_i;
          state_d = ST_REDIRECT;
        end
      end
      default: state_d = ST_RUN;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_RUN;
      pc_q    <= RESET_PC;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

endmodule

// ==== source/ifu_top.sv ====
`timescale 1ns/100ps

module ifu_top #(
  parameter fetch_pkg::addr_t RESET_PC    = fetch_pkg::DEFAULT_RESET_PC,
  parameter int               L1I_INDEX_W = 2
) (
  input  logic             clk,
  input  logic             rst,
  // Decode handshake.
  output logic             inst_valid_o,
  input  logic             inst_ready_i,
  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::addr_t pc_o,
  // Redirect from execute.
  input  logic             redirect_valid_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  // AXI4-Lite read channels.
  output fetch_pkg::addr_t araddr_o,
  output logic [2:0]       arprot_o,
  output logic             arvalid_o,
  input  logic             arready_i,
  input  fetch_pkg::inst_t rdata_i,
  input  logic [1:0]       rresp_i,
  input  logic             rvalid_i,
  output logic             rready_o
);
  import fetch_pkg::*;

  addr_t lookup_pc;
  logic  hit;
  inst_t hit_inst;
  logic  invalidate;
  logic  rd_req_valid;
  addr_t rd_req_addr;
  logic  rd_req_ready;
  logic  rd_rsp_valid;
  inst_t rd_rsp_data;

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) u_fetch_unit (
    .clk              (clk),
    .rst              (rst),
    .inst_valid_o     (inst_valid_o),
    .inst_ready_i     (inst_ready_i),
    .inst_o           (inst_o),
    .pc_o             (pc_o),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .lookup_pc_o      (lookup_pc),
    .hit_i            (hit),
    .hit_inst_i       (hit_inst),
    .invalidate_o     (invalidate)
  );

  l1i_cache #(
    .L1I_INDEX_W (L1I_INDEX_W)
  ) u_l1i_cache (
    .clk            (clk),
    .rst            (rst),
    .lookup_pc_i    (lookup_pc),
    .hit_o          (hit),
    .hit_inst_o     (hit_inst),
    .invalidate_i   (invalidate),
    .rd_req_valid_o (rd_req_valid),
    .rd_req_addr_o  (rd_req_addr),
    .rd_req_ready_i (rd_req_ready),
    .rd_rsp_valid_i (rd_rsp_valid),
    .rd_rsp_data_i  (rd_rsp_data)
  );

  axil_read_master u_axil_read_master (
    .clk            (clk),
    .rst            (rst),
    .rd_req_valid_i (rd_req_valid),
    .rd_req_addr_i  (rd_req_addr),
    .rd_req_ready_o (rd_req_ready),
    .rd_rsp_valid_o (rd_rsp_valid),
    .rd_rsp_data_o  (rd_rsp_data),
    .araddr_o       (araddr_o),
    .arprot_o       (arprot_o),
    .arvalid_o      (arvalid_o),
    .arready_i      (arready_i),
    .rdata_i        (rdata_i),
    .rresp_i        (rresp_i),
    .rvalid_i       (rvalid_i),
    .rready_o       (rready_o)
  );

endmodule

// ==== verification/axil_imem_model.sv ====
`timescale 1ns/100ps

module axil_imem_model #(
  parameter fetch_pkg::addr_t BASE = fetch_pkg::DEFAULT_RESET_PC
) (
  input  logic             clk,
  input  logic             rst,
  input  fetch_pkg::addr_t araddr_i,
  input  logic             arvalid_i,
  output logic             arready_o,
  output fetch_pkg::inst_t rdata_o,
  output logic [1:0]       rresp_o,
  output logic             rvalid_o,
  input  logic             rready_i,
  // One random bit per channel and cycle, from the testbench LFSR.
  input  logic             ar_go_i,
  input  logic             r_go_i,
  output int               ar_count_o
);
  import fetch_pkg::*;

  localparam int PROG_WORDS = 10;

  inst_t prog [PROG_WORDS];
  addr_t pend_addr;
  addr_t ar_addr;
  logic  pending;
  logic  ar_hs;
  logic  r_hs;
  logic  ar_go;
  logic  r_go;

  function automatic inst_t word_at(addr_t a);
    if (a >= BASE && a < BASE + 4 * PROG_WORDS) begin
      return prog[int'((a - BASE) >> 2)];
    end
    return {a[24:0] ^ {18'h0, a[31:25]}, 7'h13};  // OP-IMM words past the program.
  endfunction

  initial begin
    prog[0]    = 32'h0010_0093;               // addi x1, x0, 1
    prog[1]    = 32'h0020_8113;               // addi x2, x1, 2
    prog[2]    = 32'h0031_0193;               // addi x3, x2, 3
    prog[3]    = {20'hff5ff, 5'd0, OP_JAL};   // jal x0, -12
    prog[4]    = 32'h0041_8213;               // addi x4, x3, 4
    prog[5]    = INST_FENCE_I;
    prog[6]    = 32'h0052_0293;               // addi x5, x4, 5
    prog[7]    = {25'h0, OP_B_TYPE};          // beq x0, x0, 0
    prog[8]    = 32'h0062_8313;               // addi x6, x5, 6
    prog[9]    = {25'h0, OP_SYSTEM};          // ecall
    arready_o  = 1'b0;
    rvalid_o   = 1'b0;
    rdata_o    = '0;
    rresp_o    = 2'b00;
    ar_count_o = 0;
    pending    = 1'b0;
  end

  ////////////////////
  // AR and R channels
  ////////////////////

  // Handshakes are taken at the edge, outputs change 1 ns later.
  always @(posedge clk) begin
    ar_hs   = arvalid_i && arready_o;
    r_hs    = rvalid_o && rready_i;
    ar_addr = araddr_i;
    ar_go   = ar_go_i;
    r_go    = r_go_i;
    #1;
    if (rst) begin
      arready_o  = 1'b0;
      rvalid_o   = 1'b0;
      pending    = 1'b0;
      ar_count_o = 0;
    end else begin
      if (r_hs) begin
        rvalid_o = 1'b0;
        pending  = 1'b0;
      end
      if (ar_hs) begin
        pend_addr  = ar_addr;
        pending    = 1'b1;
        ar_count_o = ar_count_o + 1;
      end
      arready_o = arvalid_i && !pending && ar_go;
      if (pending && !rvalid_o && r_go) begin
        rvalid_o = 1'b1;  // Held until the master takes it.
        rdata_o  = word_at(pend_addr);
      end
    end
  end

endmodule

// ==== verification/ifu_tb.sv ====
`timescale 1ns/100ps

module ifu_tb;
  import fetch_pkg::*;

  localparam addr_t RESET_PC       = DEFAULT_RESET_PC;
  localparam addr_t RESET_LINE     = RESET_PC & ~addr_t'(LINE_WORDS * 4 - 1);
  localparam int    NUM_BRANCHES   = 5;
  localparam int    FETCHES        = 18;  // Accepted instructions over the whole run.
  localparam int    TIMEOUT_CYCLES = 40 * FETCHES + 400;
  localparam int    STALL_CYCLES   = 40;

  logic       clk;
  logic       rst;
  logic       inst_valid_o;
  logic       inst_ready_i;
  inst_t      inst_o;
  addr_t      pc_o;
  logic       redirect_valid_i;
  addr_t      redirect_pc_i;
  addr_t      araddr_o;
  logic [2:0] arprot_o;
  logic       arvalid_o;
  logic       arready_i;
  inst_t      rdata_i;
  logic [1:0] rresp_i;
  logic       rvalid_i;
  logic       rready_o;
  logic       ar_go;
  logic       r_go;
  logic       go;
  int         ar_count;
  logic       xfer;
  logic       ar_hs;
  logic       r_hs;
  logic [31:0] lfsr;

  // Reference state, updated at the edge from the bus activity.
  int    cycle_count;
  int    branch_count;
  int    outstanding;
  int    fresh_mark;
  logic  rst_q;
  logic  hold_wait;
  inst_t hold_inst;
  addr_t hold_pc;
  logic  ar_wait;
  addr_t ar_addr_q;
  addr_t exp_pc;
  logic  stalled;
  logic  refetch;
  logic  fresh_check;
  logic  ar_phase;
  addr_t line_base_q;

  int    error_count;
  int    errors_at_start;
  int    tests_closed;
  int    tests_failed;
  logic  timed_out;
  string test_names [NUM_BRANCHES] = '{"sequential fetch from reset",
    "redirect to cached lines", "fence.i and refill", "refill after fence.i",
    "system instruction stall"};

  ifu_top #(.RESET_PC(RESET_PC), .L1I_INDEX_W(2)) u_ifu_top (
    .clk(clk), .rst(rst),
    .inst_valid_o(inst_valid_o), .inst_ready_i(inst_ready_i),
    .inst_o(inst_o), .pc_o(pc_o),
    .redirect_valid_i(redirect_valid_i), .redirect_pc_i(redirect_pc_i),
    .araddr_o(araddr_o), .arprot_o(arprot_o), .arvalid_o(arvalid_o), .arready_i(arready_i),
    .rdata_i(rdata_i), .rresp_i(rresp_i), .rvalid_i(rvalid_i), .rready_o(rready_o)
  );

  axil_imem_model #(.BASE(RESET_PC)) u_imem (
    .clk(clk), .rst(rst),
    .araddr_i(araddr_o), .arvalid_i(arvalid_o), .arready_o(arready_i),
    .rdata_o(rdata_i), .rresp_o(rresp_i), .rvalid_o(rvalid_i), .rready_i(rready_o),
    .ar_go_i(ar_go), .r_go_i(r_go), .ar_count_o(ar_count)
  );

  assign xfer  = inst_valid_o && inst_ready_i;
  assign ar_hs = arvalid_o && arready_i;
  assign r_hs  = rvalid_i && rready_o;

  always #2 clk = ~clk;

  function automatic logic rand_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // Taps 32, 22, 2, 1.
    return lfsr[0];
  endfunction

  function automatic inst_t expected_word(addr_t a);
    return u_imem.prog[int'((a - RESET_PC) >> 2)];
  endfunction

  function automatic logic branch_class(inst_t w);
    return w[6:0] inside {OP_JAL, OP_JALR, OP_B_TYPE, OP_SYSTEM};
  endfunction

  // Execute's answer to the n-th branch.
  function automatic addr_t redirect_target(int n);
    case (n)
      2:       return RESET_PC + 32'h10;
      4:       return RESET_PC + 32'h20;
      default: return RESET_PC;
    endcase
  endfunction

  task automatic value_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    error_count++;
    $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  task automatic flag_problem(string msg);
    error_count++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic close_finished_tests();
    int errs;
    while (tests_closed < branch_count) begin
      errs            = error_count - errors_at_start;
      errors_at_start = error_count;
      tests_failed    = tests_failed + ((errs != 0) ? 1 : 0);
      $display("Test %0d %s: %0d errors", tests_closed + 1, test_names[tests_closed], errs);
      tests_closed++;
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    rst_q       <= rst;
    hold_wait   <= inst_valid_o && !inst_ready_i;
    hold_inst   <= inst_o;
    hold_pc     <= pc_o;
    ar_wait     <= arvalid_o && !arready_i;
    ar_addr_q   <= araddr_o;
    if (rst) begin
      exp_pc       <= RESET_PC;
      stalled      <= 1'b0;
      branch_count <= 0;
      refetch      <= 1'b0;
      fresh_check  <= 1'b0;
      ar_phase     <= 1'b0;
      outstanding  <= 0;
    end else begin
      if (xfer) begin
        fresh_check <= 1'b0;
        if (branch_class(inst_o)) begin
          stalled      <= 1'b1;
          refetch      <= 1'b0;
          branch_count <= branch_count + 1;
        end else begin
          exp_pc <= exp_pc + 32'd4;
        end
      end
      if (stalled && redirect_valid_i) begin
        stalled     <= 1'b0;
        exp_pc      <= redirect_pc_i;
        refetch     <= (branch_count == 1);  // Lines 0 and 1 are still cached.
        fresh_check <= (branch_count == 3);  // Line 0 was dropped by fence.i.
        fresh_mark  <= ar_count;
      end
      if (ar_hs) begin
        ar_phase    <= !ar_phase;
        line_base_q <= araddr_o;
      end
      outstanding <= outstanding + int'(ar_hs) - int'(r_hs);
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  assert property (@(posedge clk) disable iff (rst) xfer |-> inst_o == expected_word(pc_o))
    else value_mismatch("inst_o", expected_word($sampled(pc_o)), $sampled(inst_o));
  assert property (@(posedge clk) disable iff (rst) xfer |-> pc_o == exp_pc)
    else value_mismatch("pc_o", $sampled(exp_pc), $sampled(pc_o));
  assert property (@(posedge clk) disable iff (rst) hold_wait |-> inst_valid_o)
    else flag_problem("inst_valid_o dropped while decode was not ready");
  assert property (@(posedge clk) disable iff (rst) hold_wait |-> inst_o == hold_inst)
    else value_mismatch("inst_o", $sampled(hold_inst), $sampled(inst_o));
  assert property (@(posedge clk) disable iff (rst) hold_wait |-> pc_o == hold_pc)
    else value_mismatch("pc_o", $sampled(hold_pc), $sampled(pc_o));
  assert property (@(posedge clk) disable iff (rst) stalled |-> !inst_valid_o)
    else flag_problem("an instruction was offered before the redirect");
  assert property (@(posedge clk) disable iff (rst) refetch |-> !ar_hs)
    else flag_problem("AXI read issued while re-fetching cached lines");
  assert property (@(posedge clk) disable iff (rst) arvalid_o |-> araddr_o[1:0] == 2'b00)
    else value_mismatch("araddr_o[1:0]", 32'd0, 32'($sampled(araddr_o[1:0])));
  // AXI marks an instruction fetch with bit 2 of the protection field.
  assert property (@(posedge clk) disable iff (rst) arvalid_o |-> arprot_o[2])
    else value_mismatch("arprot_o[2]", 32'd1, 32'($sampled(arprot_o[2])));
  assert property (@(posedge clk) disable iff (rst) (ar_hs && !ar_phase) |-> !araddr_o[2])
    else flag_problem("first read of a refill is not a line base");
  assert property (@(posedge clk) disable iff (rst)
    (ar_hs && ar_phase) |-> araddr_o == line_base_q + 32'd4)
    else value_mismatch("araddr_o", $sampled(line_base_q) + 32'd4, $sampled(araddr_o));
  assert property (@(posedge clk) disable iff (rst) ar_wait |-> arvalid_o)
    else flag_problem("arvalid_o dropped before arready_i");
  assert property (@(posedge clk) disable iff (rst) ar_wait |-> araddr_o == ar_addr_q)
    else value_mismatch("araddr_o", $sampled(ar_addr_q), $sampled(araddr_o));
  assert property (@(posedge clk) disable iff (rst) rready_o |-> outstanding != 0)
    else flag_problem("rready_o high with no read outstanding");
  assert property (@(posedge clk) disable iff (rst)
    (fresh_check && xfer) |-> ar_count == fresh_mark + 2)
    else value_mismatch("AR handshake count", $sampled(fresh_mark) + 2, $sampled(ar_count));
  assert property (@(posedge clk) disable iff (rst)
    (ar_hs && ar_count == 0) |-> araddr_o == RESET_LINE)
    else value_mismatch("araddr_o", RESET_LINE, $sampled(araddr_o));
  assert property (@(posedge clk)
    (cycle_count > 0 && (rst || rst_q)) |-> !inst_valid_o && !arvalid_o)
    else flag_problem("inst_valid_o or arvalid_o high around reset");

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    clk              = 1'b0;
    rst              = 1'b1;
    inst_ready_i     = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = RESET_PC;
    ar_go            = 1'b0;
    r_go             = 1'b0;
    lfsr             = 32'h3939_178c;
    timed_out        = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    while (branch_count < NUM_BRANCHES && !timed_out) begin
      @(posedge clk);
      #1;
      if (branch_count < NUM_BRANCHES) begin
        close_finished_tests();
      end
      if (cycle_count >= TIMEOUT_CYCLES) begin
        timed_out = 1'b1;
        $display("Timeout after %0d cycles with %0d of %0d branches reached",
                 cycle_count, branch_count, NUM_BRANCHES);
      end
      inst_ready_i     = rand_bit() | rand_bit();  // Ready about three cycles in four.
      ar_go            = rand_bit();
      r_go             = rand_bit();
      go               = rand_bit();
      redirect_valid_i = stalled && go;
      redirect_pc_i    = redirect_target(branch_count);
    end
    // Execute never answers the last branch. Memory answers at once, so a PC
    // that moved on would soon be offered.
    redirect_valid_i = 1'b0;
    inst_ready_i     = 1'b1;
    ar_go            = 1'b1;
    r_go             = 1'b1;
    repeat (STALL_CYCLES) @(posedge clk);
    #1;
    close_finished_tests();
    $display("Tests run %0d, tests failed %0d, failed checks %0d",
             tests_closed, tests_failed, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
source/fetch_pkg.sv
source/axil_read_master.sv
source/l1i_cache.sv
source/fetch_unit.sv
source/ifu_top.sv
verification/axil_imem_model.sv
verification/ifu_tb.sv
